// ==== common/cfg_mem_pkg.sv ====
`default_nettype none

package cfg_mem_pkg;

  // region select, cpu address bits 16:15
  typedef enum logic [1:0] {
    sel_controller = 2'b00,
    sel_mod        = 2'b01,
    sel_duty_table = 2'b10,
    sel_stm        = 2'b11
  } bram_select_e;

  // controller register map
  // compared against word address bits 7:0, bits 13:8 must be zero
  typedef enum logic [7:0] {
    addr_ctl_flag            = 8'h00,
    addr_mod_mem_wr_segment  = 8'h01,
    addr_stm_mem_wr_segment  = 8'h02,
    addr_stm_mem_wr_page     = 8'h03,
    addr_duty_table_wr_page  = 8'h04
  } ctl_addr_e;

  // word address width inside one segment or page
  // scaled down for simulation, higher word bits wrap
  localparam int mod_word_bits  = 10;
  localparam int stm_word_bits  = 10;
  localparam int duty_word_bits = 10;

  // stm has four pages per segment
  localparam int stm_page_bits  = 2;
  // duty table has two pages
  localparam int duty_page_bits = 1;

  // one bus request from the bridge
  // valid for a single cycle per write strobe, every cycle while reading
  typedef struct packed {
    logic         valid;
    logic         we;
    bram_select_e sel;
    logic [13:0]  addr;
    logic [15:0]  data;
  } bus_req_t;

  // register file state
  // segment and page fields steer the upper memory address bits
  typedef struct packed {
    logic [15:0]               ctl_flag;
    logic                      mod_segment;
    logic                      stm_segment;
    logic [stm_page_bits-1:0]  stm_page;
    logic [duty_page_bits-1:0] duty_page;
  } ctl_state_t;

endpackage

`default_nettype wire

// ==== hdl/cpu_bus_bridge.sv ====
`default_nettype none

module cpu_bus_bridge (
  input  wire logic                CPU_CKIO,
  input  wire logic                arst_n,
  input  wire logic [16:0]         cpu_addr,
  input  wire logic                cpu_cs1_n,
  input  wire logic                cpu_we0_n,
  input  wire logic [15:0]         cpu_data_in,
  output cfg_mem_pkg::bus_req_t    req
);

  import cfg_mem_pkg::*;

  // previous sample of the write strobe
  logic we_prev;

  // request control
  logic req_valid;
  logic req_we;

  // request payload
  bram_select_e req_sel;
  logic [13:0]  req_addr;
  logic [15:0]  req_data;

  // strobe falling edge under chip select
  logic wr_hit;
  // read cycle, every sampled edge with cs low and we high
  logic rd_hit;

  assign wr_hit = ~cpu_cs1_n & ~cpu_we0_n & we_prev;
  assign rd_hit = ~cpu_cs1_n & cpu_we0_n;

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      // high after reset, no false strobe
      we_prev   <= 1'b1;
      req_valid <= 1'b0;
      req_we    <= 1'b0;
    end else begin
      we_prev   <= cpu_we0_n;
      req_valid <= wr_hit | rd_hit;
      // held low strobe gives one write only
      req_we    <= wr_hit;
    end
  end

  // payload follows the bus on every edge
  always_ff @(posedge CPU_CKIO) begin
    // top two address bits pick the region
    req_sel  <= bram_select_e'(cpu_addr[16:15]);
    // bit 0 is the byte lane, ignored
    req_addr <= cpu_addr[14:1];
    req_data <= cpu_data_in;
  end

  always_comb begin
    req.valid = req_valid;
    req.we    = req_we;
    req.sel   = req_sel;
    req.addr  = req_addr;
    req.data  = req_data;
  end

endmodule

`default_nettype wire

// ==== controller/controller_regs.sv ====
`default_nettype none

module controller_regs (
  input  wire logic                  CPU_CKIO,
  input  wire logic                  arst_n,
  input  wire cfg_mem_pkg::bus_req_t req,
  output cfg_mem_pkg::ctl_state_t    ctl_state,
  output logic [15:0]                rd_data
);

  import cfg_mem_pkg::*;

  ctl_state_t state_q;

  // request hits the register region
  logic region_hit;
  // upper word bits clear, otherwise unmapped
  logic low_page;
  logic wr_en;
  logic rd_en;

  // readback value for the addressed register
  logic [15:0] rd_value;

  assign region_hit = req.valid & (req.sel == sel_controller);
  assign low_page   = (req.addr[13:8] == 6'd0);
  assign wr_en      = region_hit & req.we & low_page;
  assign rd_en      = region_hit & ~req.we;

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= '0;
    end else if (wr_en) begin
      // unmapped addresses fall through the default
      case (req.addr[7:0])
        addr_ctl_flag: begin
          state_q.ctl_flag <= req.data;
        end
        addr_mod_mem_wr_segment: begin
          state_q.mod_segment <= req.data[0];
        end
        addr_stm_mem_wr_segment: begin
          state_q.stm_segment <= req.data[0];
        end
        addr_stm_mem_wr_page: begin
          // truncated to the page width
          state_q.stm_page <= req.data[stm_page_bits-1:0];
        end
        addr_duty_table_wr_page: begin
          state_q.duty_page <= req.data[duty_page_bits-1:0];
        end
        default: begin
          state_q <= state_q;
        end
      endcase
    end
  end

  // zero extended readback, zero when unmapped
  always_comb begin
    rd_value = 16'h0000;
    if (low_page) begin
      case (req.addr[7:0])
        addr_ctl_flag:           rd_value = state_q.ctl_flag;
        addr_mod_mem_wr_segment: rd_value = {15'd0, state_q.mod_segment};
        addr_stm_mem_wr_segment: rd_value = {15'd0, state_q.stm_segment};
        addr_stm_mem_wr_page: begin
          rd_value = {{(16 - stm_page_bits){1'b0}}, state_q.stm_page};
        end
        addr_duty_table_wr_page: begin
          rd_value = {{(16 - duty_page_bits){1'b0}}, state_q.duty_page};
        end
        default:                 rd_value = 16'h0000;
      endcase
    end
  end

  // same latency as the memories, holds between reads
  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      rd_data <= 16'h0000;
    end else if (rd_en) begin
      rd_data <= rd_value;
    end
  end

  assign ctl_state = state_q;

endmodule

`default_nettype wire

// ==== hdl/banked_ram.sv ====
`default_nettype none

module banked_ram #(
  parameter int bank_bits = 1,
  parameter int word_bits = 10
) (
  input  wire logic                 CPU_CKIO,
  input  wire logic                 wr_en,
  input  wire logic [bank_bits-1:0] wr_bank,
  input  wire logic [word_bits-1:0] wr_word,
  input  wire logic [15:0]          wr_data,
  input  wire logic                 rd_en,
  input  wire logic [bank_bits-1:0] rd_bank,
  input  wire logic [word_bits-1:0] rd_word,
  output logic [15:0]               rd_data
);

  // bank on top, word below
  localparam int addr_bits = bank_bits + word_bits;
  localparam int depth     = 1 << addr_bits;

  logic [15:0] mem [depth];

  logic [addr_bits-1:0] wr_addr;
  logic [addr_bits-1:0] rd_addr;

  assign wr_addr = {wr_bank, wr_word};
  assign rd_addr = {rd_bank, rd_word};

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, holds the last word when idle
  always_ff @(posedge CPU_CKIO) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cfg_mem_top.sv ====
`default_nettype none

module cfg_mem_top (
  input  wire logic                CPU_CKIO,
  input  wire logic                arst_n,
  input  wire logic [16:0]         cpu_addr,
  input  wire logic                cpu_cs1_n,
  input  wire logic                cpu_we0_n,
  input  wire logic [15:0]         cpu_data_in,
  output logic [15:0]              cpu_data_out,
  output cfg_mem_pkg::ctl_state_t  ctl_state
);

  import cfg_mem_pkg::*;

  bus_req_t   req;
  ctl_state_t state;

  logic wr_req;
  logic rd_req;

  // per region read data
  logic [15:0] ctl_rd_data;
  logic [15:0] mod_rd_data;
  logic [15:0] stm_rd_data;
  logic [15:0] duty_rd_data;

  // stage 2 of the read pipe
  logic         rd_valid_q;
  bram_select_e rd_sel_q;

  // stm bank is segment over page
  logic [stm_page_bits:0] stm_bank;

  cpu_bus_bridge u_bridge (
    .CPU_CKIO    (CPU_CKIO),
    .arst_n      (arst_n),
    .cpu_addr    (cpu_addr),
    .cpu_cs1_n   (cpu_cs1_n),
    .cpu_we0_n   (cpu_we0_n),
    .cpu_data_in (cpu_data_in),
    .req         (req)
  );

  controller_regs u_ctl (
    .CPU_CKIO  (CPU_CKIO),
    .arst_n    (arst_n),
    .req       (req),
    .ctl_state (state),
    .rd_data   (ctl_rd_data)
  );

  assign wr_req   = req.valid & req.we;
  assign rd_req   = req.valid & ~req.we;
  assign stm_bank = {state.stm_segment, state.stm_page};

  // reads and writes both use the write segment and page
  // word address truncated, so out of range words wrap
  banked_ram #(
    .bank_bits (1),
    .word_bits (mod_word_bits)
  ) u_mod (
    .CPU_CKIO (CPU_CKIO),
    .wr_en    (wr_req & (req.sel == sel_mod)),
    .wr_bank  (state.mod_segment),
    .wr_word  (req.addr[mod_word_bits-1:0]),
    .wr_data  (req.data),
    .rd_en    (rd_req & (req.sel == sel_mod)),
    .rd_bank  (state.mod_segment),
    .rd_word  (req.addr[mod_word_bits-1:0]),
    .rd_data  (mod_rd_data)
  );

  banked_ram #(
    .bank_bits (1 + stm_page_bits),
    .word_bits (stm_word_bits)
  ) u_stm (
    .CPU_CKIO (CPU_CKIO),
    .wr_en    (wr_req & (req.sel == sel_stm)),
    .wr_bank  (stm_bank),
    .wr_word  (req.addr[stm_word_bits-1:0]),
    .wr_data  (req.data),
    .rd_en    (rd_req & (req.sel == sel_stm)),
    .rd_bank  (stm_bank),
    .rd_word  (req.addr[stm_word_bits-1:0]),
    .rd_data  (stm_rd_data)
  );

  banked_ram #(
    .bank_bits (duty_page_bits),
    .word_bits (duty_word_bits)
  ) u_duty (
    .CPU_CKIO (CPU_CKIO),
    .wr_en    (wr_req & (req.sel == sel_duty_table)),
    .wr_bank  (state.duty_page),
    .wr_word  (req.addr[duty_word_bits-1:0]),
    .wr_data  (req.data),
    .rd_en    (rd_req & (req.sel == sel_duty_table)),
    .rd_bank  (state.duty_page),
    .rd_word  (req.addr[duty_word_bits-1:0]),
    .rd_data  (duty_rd_data)
  );

  // select travels alongside the region read
  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid_q   <= 1'b0;
      rd_sel_q     <= sel_controller;
      cpu_data_out <= 16'h0000;
    end else begin
      rd_valid_q <= rd_req;
      rd_sel_q   <= req.sel;
      // output mux, third pipe stage
      if (rd_valid_q) begin
        case (rd_sel_q)
          sel_controller: cpu_data_out <= ctl_rd_data;
          sel_mod:        cpu_data_out <= mod_rd_data;
          sel_duty_table: cpu_data_out <= duty_rd_data;
          sel_stm:        cpu_data_out <= stm_rd_data;
          default:        cpu_data_out <= 16'h0000;
        endcase
      end
    end
  end

  assign ctl_state = state;

endmodule

`default_nettype wire

// ==== verif/cfg_mem_sva.sv ====
`default_nettype none

module cfg_mem_sva (
  input wire logic                  CPU_CKIO,
  input wire logic                  arst_n,
  input wire logic                  cpu_cs1_n,
  input wire logic                  cpu_we0_n,
  input wire cfg_mem_pkg::bus_req_t req
);

  timeunit 1ns;
  timeprecision 1ps;

  // write request as seen at the bridge output
  logic wr_req;

  assign wr_req = req.valid & req.we;

  // one strobe, one single cycle request
  property p_wr_single;
    @(posedge CPU_CKIO) disable iff (!arst_n)
      wr_req |=> !wr_req;
  endproperty

  // strobe sampled high, then low under chip select
  property p_wr_after_edge;
    @(posedge CPU_CKIO) disable iff (!arst_n)
      wr_req |-> ($past(cpu_we0_n, 2) && !$past(cpu_we0_n) && !$past(cpu_cs1_n));
  endproperty

  // no request while deselected
  property p_idle_when_deselected;
    @(posedge CPU_CKIO) disable iff (!arst_n)
      $past(cpu_cs1_n) |-> !req.valid;
  endproperty

  a_wr_single: assert property (p_wr_single)
    else $error("bridge write request lasted more than one cycle");
  a_wr_after_edge: assert property (p_wr_after_edge)
    else $error("bridge write request without a falling write strobe");
  a_idle_when_deselected: assert property (p_idle_when_deselected)
    else $error("bridge request valid while chip select was high");

endmodule

bind cpu_bus_bridge cfg_mem_sva u_bridge_sva (
  .CPU_CKIO  (CPU_CKIO),
  .arst_n    (arst_n),
  .cpu_cs1_n (cpu_cs1_n),
  .cpu_we0_n (cpu_we0_n),
  .req       (req)
);

`default_nettype wire

// ==== verif/tb_cfg_mem.sv ====
`default_nettype none

module tb_cfg_mem;

  timeunit 1ns;
  timeprecision 1ps;

  import cfg_mem_pkg::*;

  // upper bound on bus ops over all tests
  // each op takes at most 6 cycles
  localparam int num_bus_ops    = 180;
  localparam int timeout_cycles = num_bus_ops * 6 + 100;

  logic        CPU_CKIO;
  logic        arst_n;
  logic [16:0] cpu_addr;
  logic        cpu_cs1_n;
  logic        cpu_we0_n;
  logic [15:0] cpu_data_in;
  logic [15:0] cpu_data_out;
  ctl_state_t  ctl_state;

  // reference model with register state and one array per region
  ctl_state_t  m_state;
  logic [15:0] m_mod  [1 << (1 + mod_word_bits)];
  logic [15:0] m_stm  [1 << (1 + stm_page_bits + stm_word_bits)];
  logic [15:0] m_duty [1 << (duty_page_bits + duty_word_bits)];

  integer seed;
  int     errors;
  int     checks;

  cfg_mem_top UUT (
    .CPU_CKIO     (CPU_CKIO),
    .arst_n       (arst_n),
    .cpu_addr     (cpu_addr),
    .cpu_cs1_n    (cpu_cs1_n),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_data_in  (cpu_data_in),
    .cpu_data_out (cpu_data_out),
    .ctl_state    (ctl_state)
  );

  initial begin
    CPU_CKIO = 1'b0;
    forever #5 CPU_CKIO = ~CPU_CKIO;
  end

  // watchdog
  initial begin
    repeat (timeout_cycles) @(posedge CPU_CKIO);
    $display("watchdog: no verdict after %0d cycles", timeout_cycles);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [16:0] bus_addr(bram_select_e sel, logic [13:0] word);
    // region on top and byte lane bit 0 unused
    return {sel, word, 1'b0};
  endfunction

  function automatic logic [15:0] rand_word();
    return 16'($random(seed));
  endfunction

  task automatic check_word(string name, logic [15:0] got, logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_ctl(ctl_state_t got, ctl_state_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL ctl_state: got %h, expected %h", got, exp);
    end
  endtask

  // called right after a rising edge
  task automatic drive_bus(logic cs_n, logic we_n, logic [16:0] addr, logic [15:0] data);
    cpu_cs1_n   <= cs_n;
    cpu_we0_n   <= we_n;
    cpu_addr    <= addr;
    cpu_data_in <= data;
  endtask

  // strobe low for one cycle
  // committed two edges after the sample
  task automatic bus_write(logic [16:0] addr, logic [15:0] data);
    @(posedge CPU_CKIO);
    drive_bus(1'b0, 1'b0, addr, data);
    @(posedge CPU_CKIO);
    drive_bus(1'b1, 1'b1, addr, data);
    @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
  endtask

  // data sampled at edge N is on cpu_data_out after edge N+2
  task automatic bus_read(input logic [16:0] addr, output logic [15:0] data);
    @(posedge CPU_CKIO);
    drive_bus(1'b0, 1'b1, addr, 16'h0000);
    @(posedge CPU_CKIO);
    drive_bus(1'b1, 1'b1, addr, 16'h0000);
    repeat (2) @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
    data = cpu_data_out;
  endtask

  // model of a committed write
  // upper word bits dropped for the wrap
  task automatic model_write(bram_select_e sel, logic [13:0] word, logic [15:0] data);
    case (sel)
      sel_controller: begin
        if (word[13:8] == 6'd0) begin
          case (word[7:0])
            addr_ctl_flag:           m_state.ctl_flag = data;
            addr_mod_mem_wr_segment: m_state.mod_segment = data[0];
            addr_stm_mem_wr_segment: m_state.stm_segment = data[0];
            addr_stm_mem_wr_page:    m_state.stm_page = data[stm_page_bits-1:0];
            addr_duty_table_wr_page: m_state.duty_page = data[duty_page_bits-1:0];
            default: begin
            end
          endcase
        end
      end
      sel_mod: m_mod[{m_state.mod_segment, word[mod_word_bits-1:0]}] = data;
      sel_stm: begin
        m_stm[{m_state.stm_segment, m_state.stm_page, word[stm_word_bits-1:0]}] = data;
      end
      default: m_duty[{m_state.duty_page, word[duty_word_bits-1:0]}] = data;
    endcase
  endtask

  // reads come from the selected write segment and page
  function automatic logic [15:0] model_read(bram_select_e sel, logic [13:0] word);
    logic [15:0] value;
    value = 16'h0000;
    case (sel)
      sel_controller: begin
        if (word[13:8] == 6'd0) begin
          case (word[7:0])
            addr_ctl_flag:           value = m_state.ctl_flag;
            addr_mod_mem_wr_segment: value = 16'(m_state.mod_segment);
            addr_stm_mem_wr_segment: value = 16'(m_state.stm_segment);
            addr_stm_mem_wr_page:    value = 16'(m_state.stm_page);
            addr_duty_table_wr_page: value = 16'(m_state.duty_page);
            default:                 value = 16'h0000;
          endcase
        end
      end
      sel_mod: value = m_mod[{m_state.mod_segment, word[mod_word_bits-1:0]}];
      sel_stm: value = m_stm[{m_state.stm_segment, m_state.stm_page, word[stm_word_bits-1:0]}];
      default: value = m_duty[{m_state.duty_page, word[duty_word_bits-1:0]}];
    endcase
    return value;
  endfunction

  task automatic cpu_write(bram_select_e sel, logic [13:0] word, logic [15:0] data);
    bus_write(bus_addr(sel, word), data);
    model_write(sel, word, data);
  endtask

  task automatic cpu_read_check(string name, bram_select_e sel, logic [13:0] word);
    logic [15:0] got;
    bus_read(bus_addr(sel, word), got);
    check_word(name, got, model_read(sel, word));
  endtask

  task automatic select_stm(logic [15:0] seg, logic [15:0] page);
    cpu_write(sel_controller, 14'(addr_stm_mem_wr_segment), seg);
    cpu_write(sel_controller, 14'(addr_stm_mem_wr_page), page);
  endtask

  task automatic test_reset();
    check_ctl(ctl_state, '0);
    check_word("cpu_data_out", cpu_data_out, 16'h0000);
  endtask

  task automatic test_ctl_regs();
    ctl_addr_e   regs [5];
    logic [15:0] got;
    regs = '{addr_ctl_flag, addr_mod_mem_wr_segment, addr_stm_mem_wr_segment,
             addr_stm_mem_wr_page, addr_duty_table_wr_page};
    // random data also exercises truncation
    foreach (regs[i]) begin
      cpu_write(sel_controller, 14'(regs[i]), rand_word());
      check_ctl(ctl_state, m_state);
    end
    foreach (regs[i]) cpu_read_check("ctl readback", sel_controller, 14'(regs[i]));
    // oversized page values keep only the low bits
    cpu_write(sel_controller, 14'(addr_stm_mem_wr_page), 16'h0006);
    cpu_write(sel_controller, 14'(addr_duty_table_wr_page), 16'h0003);
    bus_read(bus_addr(sel_controller, 14'(addr_stm_mem_wr_page)), got);
    check_word("stm page readback", got, 16'h0002);
    bus_read(bus_addr(sel_controller, 14'(addr_duty_table_wr_page)), got);
    check_word("duty page readback", got, 16'h0001);
    check_ctl(ctl_state, m_state);
    // known nonzero flag so an aliased write or read shows up
    cpu_write(sel_controller, 14'(addr_ctl_flag), 16'h5a5a);
    // unmapped addresses incl. one that aliases ctl_flag in the low byte
    cpu_write(sel_controller, 14'h0005, 16'hffff);
    cpu_write(sel_controller, 14'h0100, 16'ha5a5);
    check_ctl(ctl_state, m_state);
    bus_read(bus_addr(sel_controller, 14'h0005), got);
    check_word("unmapped readback", got, 16'h0000);
    bus_read(bus_addr(sel_controller, 14'h0100), got);
    check_word("unmapped readback", got, 16'h0000);
  endtask

  task automatic test_mod_segments();
    // same words in both segments
    for (int seg = 0; seg < 2; seg++) begin
      cpu_write(sel_controller, 14'(addr_mod_mem_wr_segment), 16'(seg));
      for (int i = 0; i < 4; i++) cpu_write(sel_mod, 14'(i * 97 + 3), rand_word());
    end
    for (int seg = 0; seg < 2; seg++) begin
      cpu_write(sel_controller, 14'(addr_mod_mem_wr_segment), 16'(seg));
      for (int i = 0; i < 4; i++) cpu_read_check("mod readback", sel_mod, 14'(i * 97 + 3));
    end
  endtask

  task automatic test_stm_duty_pages();
    // same sparse words on every page of both segments
    for (int seg = 0; seg < 2; seg++) begin
      for (int page = 0; page < 4; page++) begin
        select_stm(16'(seg), 16'(page));
        for (int i = 0; i < 3; i++) cpu_write(sel_stm, 14'(i * 331 + 7), rand_word());
      end
    end
    for (int seg = 0; seg < 2; seg++) begin
      for (int page = 0; page < 4; page++) begin
        select_stm(16'(seg), 16'(page));
        for (int i = 0; i < 3; i++) begin
          cpu_read_check("stm readback", sel_stm, 14'(i * 331 + 7));
        end
      end
    end
    for (int page = 0; page < 2; page++) begin
      cpu_write(sel_controller, 14'(addr_duty_table_wr_page), 16'(page));
      for (int i = 0; i < 3; i++) cpu_write(sel_duty_table, 14'(i * 211 + 17), rand_word());
    end
    for (int page = 0; page < 2; page++) begin
      cpu_write(sel_controller, 14'(addr_duty_table_wr_page), 16'(page));
      for (int i = 0; i < 3; i++) begin
        cpu_read_check("duty readback", sel_duty_table, 14'(i * 211 + 17));
      end
    end
  endtask

  task automatic test_wrap_and_strobe();
    logic [15:0] d;
    logic [15:0] got;
    int          wr_count;
    // one depth above lands on the same word
    d = rand_word();
    cpu_write(sel_mod, 14'((1 << mod_word_bits) + 5), d);
    bus_read(bus_addr(sel_mod, 14'd5), got);
    check_word("mod wrap", got, d);
    select_stm(16'h0001, 16'h0002);
    d = rand_word();
    cpu_write(sel_stm, 14'(3 * (1 << stm_word_bits) + 9), d);
    bus_read(bus_addr(sel_stm, 14'd9), got);
    check_word("stm wrap", got, d);
    // strobe held for five cycles gives one request
    d = rand_word();
    wr_count = 0;
    for (int i = 0; i < 7; i++) begin
      @(posedge CPU_CKIO);
      if (i < 5) drive_bus(1'b0, 1'b0, bus_addr(sel_duty_table, 14'd20), d);
      else drive_bus(1'b1, 1'b1, bus_addr(sel_duty_table, 14'd20), d);
      @(negedge CPU_CKIO);
      if (UUT.req.valid && UUT.req.we) wr_count++;
    end
    model_write(sel_duty_table, 14'd20, d);
    if (wr_count != 1) begin
      errors++;
      $display("held write strobe produced %0d write requests instead of one", wr_count);
    end
    cpu_read_check("duty after long strobe", sel_duty_table, 14'd20);
  endtask

  task automatic test_pipelined_reads();
    bram_select_e sels  [8];
    logic [13:0]  words [8];
    logic [15:0]  exp   [8];
    sels  = '{sel_mod, sel_controller, sel_stm, sel_duty_table,
              sel_stm, sel_mod, sel_controller, sel_duty_table};
    words = '{14'd40, 14'(addr_ctl_flag), 14'd41, 14'd42,
              14'd43, 14'd44, 14'(addr_stm_mem_wr_page), 14'd45};
    foreach (sels[i]) begin
      if (sels[i] != sel_controller) cpu_write(sels[i], words[i], rand_word());
    end
    foreach (sels[i]) exp[i] = model_read(sels[i], words[i]);
    // one read per cycle with the result three iterations later
    for (int i = 0; i < 11; i++) begin
      @(posedge CPU_CKIO);
      if (i < 8) drive_bus(1'b0, 1'b1, bus_addr(sels[i], words[i]), 16'h0000);
      else drive_bus(1'b1, 1'b1, cpu_addr, 16'h0000);
      @(negedge CPU_CKIO);
      if (i >= 3) check_word("cpu_data_out pipelined", cpu_data_out, exp[i - 3]);
    end
  endtask

  initial begin
    seed        = 79164;
    errors      = 0;
    checks      = 0;
    m_state     = '0;
    arst_n      = 1'b0;
    cpu_addr    = '0;
    cpu_cs1_n   = 1'b1;
    cpu_we0_n   = 1'b1;
    cpu_data_in = '0;
    repeat (2) @(posedge CPU_CKIO);
    arst_n <= 1'b1;
    @(negedge CPU_CKIO);
    test_reset();
    test_ctl_regs();
    test_mod_segments();
    test_stm_duty_pages();
    test_wrap_and_strobe();
    test_pipelined_reads();
    $display("tb_cfg_mem: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
common/cfg_mem_pkg.sv
hdl/cpu_bus_bridge.sv
controller/controller_regs.sv
hdl/banked_ram.sv
hdl/cfg_mem_top.sv
verif/cfg_mem_sva.sv
verif/tb_cfg_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cfg_mem testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
  --top-module tb_cfg_mem -Mdir obj_dir -o tb_cfg_mem > build.log 2>&1 &&
  ./obj_dir/tb_cfg_mem > sim.log 2>&1 ||
  echo "build or simulation exited with an error, see build.log" >> sim.log
cat sim.log
grep -q -e "TEST FAILED" -e "%Error" -e "exited with an error" sim.log &&
  { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
